//--- design/dma_bus_fsm.sv
/* host side of the DMA engine
   takes operations, frames transmit data and delivers receive data to the host */
module dma_bus_fsm (
   input  logic cpci_clk,
   input  logic reset,
   input  logic dma_enable,
   input  logic dma_op_valid,
   input  logic dma_op_code,
   input  logic [3:0] dma_op_queue_id,
   output logic dma_op_ready,
   input  logic dma_c2n_valid,
   input  logic [dma_defs_pkg::dma_data_width-1:0] dma_c2n_data,
   output logic dma_c2n_ready,
   output logic dma_n2c_valid,
   output logic [dma_defs_pkg::dma_data_width-1:0] dma_n2c_data,
   output logic dma_n2c_eop,
   output dma_defs_pkg::valid_bytes_t dma_n2c_valid_bytes,
   input  logic dma_n2c_ready,
   input  logic txf_wr_ready,
   output logic txf_wr_valid,
   output dma_defs_pkg::tx_word_t txf_wr_data,
   input  logic rxf_rd_valid,
   input  dma_defs_pkg::rx_word_t rxf_rd_data,
   output logic rxf_rd_ready
);
   import dma_defs_pkg::*;

   typedef enum logic [1:0] {
      st_idle,
      st_tx_len,
      st_tx_data,
      st_rx_drain
   } state_t;

   state_t state;
   logic [pkt_len_width-1:0] bytes_left;
   logic op_fire;
   logic c2n_fire;
   logic n2c_fire;
   logic last_word;

   ////////////////////////////////////////////////////////////
   // operation handshake and transmit framing
   ////////////////////////////////////////////////////////////

   // request word needs a free fifo slot
   // low while reset is held
   assign dma_op_ready = !reset && (state == st_idle) && dma_enable && txf_wr_ready;
   assign op_fire = dma_op_valid && dma_op_ready;

   // length word is swallowed while data words wait for room
   assign dma_c2n_ready = (state == st_tx_len) || ((state == st_tx_data) && txf_wr_ready);
   assign c2n_fire = dma_c2n_valid && dma_c2n_ready;
   assign last_word = (bytes_left <= pkt_len_width'(4));

   always_comb begin
      txf_wr_valid = op_fire || (c2n_fire && (state == st_tx_data));
      txf_wr_data = '0;
      if (state == st_idle) begin
         // request word with the op code in eop
         txf_wr_data.is_req = 1'b1;
         txf_wr_data.eop = dma_op_code;
         txf_wr_data.data = dma_data_width'(dma_op_queue_id);
      end else begin
         // remaining bytes mod 4 on the last word
         txf_wr_data.eop = last_word;
         txf_wr_data.valid_bytes = last_word ? valid_bytes_t'(bytes_left[1:0]) : '0;
         txf_wr_data.data = dma_c2n_data;
      end
   end

   ////////////////////////////////////////////////////////////
   // receive delivery straight from the fifo head
   ////////////////////////////////////////////////////////////

   // head holds still while the host stalls
   assign dma_n2c_valid = (state == st_rx_drain) && rxf_rd_valid;
   assign dma_n2c_data = rxf_rd_data.data;
   assign dma_n2c_eop = rxf_rd_data.eop;
   assign dma_n2c_valid_bytes = rxf_rd_data.valid_bytes;
   assign rxf_rd_ready = (state == st_rx_drain) && dma_n2c_ready;
   assign n2c_fire = dma_n2c_valid && dma_n2c_ready;

   always_ff @(posedge cpci_clk) begin
      if (reset) begin
         state <= st_idle;
      end else begin
         case (state)
            st_idle:
               if (op_fire)
                  state <= (dma_op_code == dma_op_tx) ? st_tx_len : st_rx_drain;
            st_tx_len:
               if (c2n_fire)
                  state <= st_tx_data;
            st_tx_data:
               if (c2n_fire && last_word)
                  state <= st_idle;
            st_rx_drain:
               if (n2c_fire && dma_n2c_eop)
                  state <= st_idle;
            default:
               state <= st_idle;
         endcase
      end
   end

   // byte countdown loaded from bits 10:0 of the length word
   always_ff @(posedge cpci_clk) begin
      if ((state == st_tx_len) && c2n_fire)
         bytes_left <= dma_c2n_data[pkt_len_width-1:0];
      else if ((state == st_tx_data) && c2n_fire)
         bytes_left <= bytes_left - pkt_len_width'(4);
   end

endmodule

//--- design/dma_defs_pkg.sv
/* word formats, widths and op codes of the DMA datapath
   imported by the host FSM, the queue interface and the top level */
package dma_defs_pkg;

   // queue count and id width
   localparam int num_cpu_queues = 4;
   localparam int queue_id_width = $clog2(num_cpu_queues);

   // one data word plus one ctrl bit per byte
   localparam int dma_data_width = 32;
   localparam int dma_ctrl_width = dma_data_width / 8;

   // flattened buses towards the four cpu queues
   localparam int q_data_width = num_cpu_queues * dma_data_width;
   localparam int q_ctrl_width = num_cpu_queues * dma_ctrl_width;

   // length field in bits 10:0 of the first host word
   localparam int pkt_len_width = 11;
   localparam int fifo_depth = 16;

   // op codes, sent in the eop bit of a request word
   localparam logic dma_op_tx = 1'b0;
   localparam logic dma_op_rx = 1'b1;

   // 0 is a full word, 1..3 is that many bytes
   typedef logic [1:0] valid_bytes_t;

   // host to core, either a request or a data word
   typedef struct packed {
      logic is_req;
      logic eop;
      valid_bytes_t valid_bytes;
      logic [dma_data_width-1:0] data;
   } tx_word_t;

   // core to host
   typedef struct packed {
      logic eop;
      valid_bytes_t valid_bytes;
      logic [dma_data_width-1:0] data;
   } rx_word_t;

endpackage

//--- design/dma_que_intfc.sv
/* core side of the DMA engine
   runs requests from the transmit FIFO against the four CPU queues */
module dma_que_intfc (
   input  logic cpci_clk,
   input  logic reset,
   input  logic txf_rd_valid,
   input  dma_defs_pkg::tx_word_t txf_rd_data,
   output logic txf_rd_ready,
   input  logic rxf_wr_ready,
   output logic rxf_wr_valid,
   output dma_defs_pkg::rx_word_t rxf_wr_data,
   input  logic [dma_defs_pkg::num_cpu_queues-1:0] cpu_q_dma_pkt_avail,
   output logic [dma_defs_pkg::num_cpu_queues-1:0] cpu_q_dma_rd,
   input  logic [dma_defs_pkg::q_data_width-1:0] cpu_q_dma_rd_data,
   input  logic [dma_defs_pkg::q_ctrl_width-1:0] cpu_q_dma_rd_ctrl,
   input  logic [dma_defs_pkg::num_cpu_queues-1:0] cpu_q_dma_nearly_full,
   output logic [dma_defs_pkg::num_cpu_queues-1:0] cpu_q_dma_wr,
   output logic [dma_defs_pkg::q_data_width-1:0] cpu_q_dma_wr_data,
   output logic [dma_defs_pkg::q_ctrl_width-1:0] cpu_q_dma_wr_ctrl,
   output logic pkt_ingress,
   output logic pkt_egress,
   output logic [11:0] pkt_len
);
   import dma_defs_pkg::*;

   typedef enum logic [1:0] {
      q_idle,
      q_tx,
      q_rx_wait,
      q_rx
   } state_t;

   state_t state;
   logic [queue_id_width-1:0] q_sel;
   logic rd_pend;
   logic [11:0] byte_sum;
   logic tx_fire;
   logic rd_strobe;
   logic word_fire;
   logic word_eop;
   logic [2:0] word_bytes;
   logic [dma_ctrl_width-1:0] wr_ctrl;
   logic [dma_ctrl_width-1:0] rd_ctrl;

   // last word gets one bit at 4 minus the byte count
   function automatic logic [dma_ctrl_width-1:0] enc_ctrl(valid_bytes_t vb);
      if (vb == 2'd0)
         return dma_ctrl_width'(1);
      return dma_ctrl_width'(1) << (3'd4 - 3'(vb));
   endfunction

   function automatic valid_bytes_t dec_ctrl(logic [dma_ctrl_width-1:0] ctrl);
      if (ctrl[3])
         return 2'd1;
      if (ctrl[2])
         return 2'd2;
      if (ctrl[1])
         return 2'd3;
      return 2'd0;
   endfunction

   ////////////////////////////////////////////////////////////
   // transmit: fifo head to the selected queue
   ////////////////////////////////////////////////////////////

   // writes only while the queue has room
   assign tx_fire = (state == q_tx) && txf_rd_valid && !cpu_q_dma_nearly_full[q_sel];
   // idle pops the request word
   assign txf_rd_ready = (state == q_idle) || tx_fire;
   assign wr_ctrl = txf_rd_data.eop ? enc_ctrl(txf_rd_data.valid_bytes) : '0;

   // data and ctrl shared, the strobe picks the queue
   assign cpu_q_dma_wr = tx_fire ? (num_cpu_queues'(1) << q_sel) : '0;
   assign cpu_q_dma_wr_data = {num_cpu_queues{txf_rd_data.data}};
   assign cpu_q_dma_wr_ctrl = {num_cpu_queues{wr_ctrl}};

   ////////////////////////////////////////////////////////////
   // receive: one read in flight, data one cycle after strobe
   ////////////////////////////////////////////////////////////

   // no push is pending at strobe time so the slot is still free
   assign rd_strobe = (state == q_rx) && !rd_pend && rxf_wr_ready;
   assign cpu_q_dma_rd = rd_strobe ? (num_cpu_queues'(1) << q_sel) : '0;
   assign rd_ctrl = cpu_q_dma_rd_ctrl[q_sel*dma_ctrl_width +: dma_ctrl_width];

   assign rxf_wr_valid = (state == q_rx) && rd_pend;
   assign rxf_wr_data.eop = |rd_ctrl;
   assign rxf_wr_data.valid_bytes = dec_ctrl(rd_ctrl);
   assign rxf_wr_data.data = cpu_q_dma_rd_data[q_sel*dma_data_width +: dma_data_width];

   // per word byte count for the counters
   assign word_fire = tx_fire || rxf_wr_valid;
   assign word_eop = (state == q_tx) ? txf_rd_data.eop : rxf_wr_data.eop;
   assign word_bytes = ((state == q_tx) ? txf_rd_data.valid_bytes : rxf_wr_data.valid_bytes)
                       == 2'd0 ? 3'd4 :
                       3'((state == q_tx) ? txf_rd_data.valid_bytes : rxf_wr_data.valid_bytes);

   always_ff @(posedge cpci_clk) begin
      if (reset) begin
         state <= q_idle;
         rd_pend <= 1'b0;
         pkt_ingress <= 1'b0;
         pkt_egress <= 1'b0;
      end else begin
         rd_pend <= rd_strobe;
         pkt_ingress <= tx_fire && txf_rd_data.eop;
         pkt_egress <= rxf_wr_valid && rxf_wr_data.eop;
         case (state)
            q_idle:
               if (txf_rd_valid && txf_rd_data.is_req)
                  state <= (txf_rd_data.eop == dma_op_tx) ? q_tx : q_rx_wait;
            q_tx:
               if (tx_fire && txf_rd_data.eop)
                  state <= q_idle;
            // avail is only sampled before the first read
            q_rx_wait:
               if (cpu_q_dma_pkt_avail[q_sel])
                  state <= q_rx;
            q_rx:
               if (rxf_wr_valid && rxf_wr_data.eop)
                  state <= q_idle;
            default:
               state <= q_idle;
         endcase
      end
   end

   // queue number and byte sum, restarted while idle
   always_ff @(posedge cpci_clk) begin
      if (state == q_idle) begin
         q_sel <= txf_rd_data.data[queue_id_width-1:0];
         byte_sum <= '0;
      end else if (word_fire) begin
         byte_sum <= byte_sum + 12'(word_bytes);
      end
      if (word_fire && word_eop)
         pkt_len <= byte_sum + 12'(word_bytes);
   end

endmodule

//--- design/dma_reg_pkg.sv
/* register map of the DMA block
   addresses, control bits and register bus widths */
package dma_reg_pkg;

   localparam int dma_reg_addr_width = 3;
   localparam int reg_data_width = 32;

   // register addresses, anything else reads 0
   localparam logic [dma_reg_addr_width-1:0] reg_ctrl_addr = 3'd0;
   localparam logic [dma_reg_addr_width-1:0] reg_rx_pkts_addr = 3'd1;
   localparam logic [dma_reg_addr_width-1:0] reg_rx_bytes_addr = 3'd2;
   localparam logic [dma_reg_addr_width-1:0] reg_tx_pkts_addr = 3'd3;
   localparam logic [dma_reg_addr_width-1:0] reg_tx_bytes_addr = 3'd4;

   // control register bits
   localparam int ctrl_enable_bit = 0;
   // write-one, never reads back
   localparam int ctrl_clear_bit = 1;

endpackage

//--- design/dma_regs.sv
/* DMA control register and traffic counters
   one-cycle acknowledge on the request/acknowledge register bus */
module dma_regs (
   input  logic cpci_clk,
   input  logic reset,
   input  logic reg_req,
   input  logic reg_rd_wr_l,
   input  logic [dma_reg_pkg::dma_reg_addr_width-1:0] reg_addr,
   input  logic [dma_reg_pkg::reg_data_width-1:0] reg_wr_data,
   output logic [dma_reg_pkg::reg_data_width-1:0] reg_rd_data,
   output logic reg_ack,
   output logic dma_enable,
   input  logic pkt_ingress,
   input  logic pkt_egress,
   input  logic [11:0] pkt_len
);
   import dma_reg_pkg::*;

   logic [reg_data_width-1:0] rx_pkts;
   logic [reg_data_width-1:0] rx_bytes;
   logic [reg_data_width-1:0] tx_pkts;
   logic [reg_data_width-1:0] tx_bytes;
   logic ctrl_wr;
   logic cnt_clear;

   assign ctrl_wr = reg_req && !reg_rd_wr_l && (reg_addr == reg_ctrl_addr);
   assign cnt_clear = ctrl_wr && reg_wr_data[ctrl_clear_bit];

   always_ff @(posedge cpci_clk) begin
      if (reset) begin
         // engine comes up enabled
         dma_enable <= 1'b1;
         reg_ack <= 1'b0;
      end else begin
         reg_ack <= reg_req;
         if (ctrl_wr)
            dma_enable <= reg_wr_data[ctrl_enable_bit];
      end
   end

   // clear wins over a same-cycle packet pulse
   always_ff @(posedge cpci_clk) begin
      if (reset || cnt_clear) begin
         rx_pkts <= '0;
         rx_bytes <= '0;
         tx_pkts <= '0;
         tx_bytes <= '0;
      end else begin
         if (pkt_egress) begin
            rx_pkts <= rx_pkts + 1'b1;
            rx_bytes <= rx_bytes + reg_data_width'(pkt_len);
         end
         if (pkt_ingress) begin
            tx_pkts <= tx_pkts + 1'b1;
            tx_bytes <= tx_bytes + reg_data_width'(pkt_len);
         end
      end
   end

   // read data lines up with reg_ack
   always_ff @(posedge cpci_clk) begin
      reg_rd_data <= '0;
      if (reg_req && reg_rd_wr_l) begin
         case (reg_addr)
            reg_ctrl_addr:     reg_rd_data <= reg_data_width'(dma_enable) << ctrl_enable_bit;
            reg_rx_pkts_addr:  reg_rd_data <= rx_pkts;
            reg_rx_bytes_addr: reg_rd_data <= rx_bytes;
            reg_tx_pkts_addr:  reg_rd_data <= tx_pkts;
            reg_tx_bytes_addr: reg_rd_data <= tx_bytes;
            default:           reg_rd_data <= '0;
         endcase
      end
   end

endmodule

//--- design/dma_top.sv
/* top level of the packet DMA engine
   host FSM, transmit and receive FIFOs, queue interface and registers */
module dma_top (
   input  logic cpci_clk,
   input  logic reset,
   // host operation
   input  logic dma_op_valid,
   input  logic dma_op_code,
   input  logic [3:0] dma_op_queue_id,
   output logic dma_op_ready,
   // host transmit data
   input  logic dma_c2n_valid,
   input  logic [dma_defs_pkg::dma_data_width-1:0] dma_c2n_data,
   output logic dma_c2n_ready,
   // host receive data
   output logic dma_n2c_valid,
   output logic [dma_defs_pkg::dma_data_width-1:0] dma_n2c_data,
   output logic dma_n2c_eop,
   output dma_defs_pkg::valid_bytes_t dma_n2c_valid_bytes,
   input  logic dma_n2c_ready,
   // cpu receive queues
   input  logic [dma_defs_pkg::num_cpu_queues-1:0] cpu_q_dma_pkt_avail,
   output logic [dma_defs_pkg::num_cpu_queues-1:0] cpu_q_dma_rd,
   input  logic [dma_defs_pkg::q_data_width-1:0] cpu_q_dma_rd_data,
   input  logic [dma_defs_pkg::q_ctrl_width-1:0] cpu_q_dma_rd_ctrl,
   // cpu transmit queues
   input  logic [dma_defs_pkg::num_cpu_queues-1:0] cpu_q_dma_nearly_full,
   output logic [dma_defs_pkg::num_cpu_queues-1:0] cpu_q_dma_wr,
   output logic [dma_defs_pkg::q_data_width-1:0] cpu_q_dma_wr_data,
   output logic [dma_defs_pkg::q_ctrl_width-1:0] cpu_q_dma_wr_ctrl,
   // register bus
   input  logic reg_req,
   input  logic reg_rd_wr_l,
   input  logic [dma_reg_pkg::dma_reg_addr_width-1:0] reg_addr,
   input  logic [dma_reg_pkg::reg_data_width-1:0] reg_wr_data,
   output logic [dma_reg_pkg::reg_data_width-1:0] reg_rd_data,
   output logic reg_ack
);
   import dma_defs_pkg::*;

   // transmit fifo, requests and data words
   tx_word_t txf_wr_data;
   tx_word_t txf_rd_data;
   logic txf_wr_valid;
   logic txf_wr_ready;
   logic txf_rd_valid;
   logic txf_rd_ready;

   // receive fifo
   rx_word_t rxf_wr_data;
   rx_word_t rxf_rd_data;
   logic rxf_wr_valid;
   logic rxf_wr_ready;
   logic rxf_rd_valid;
   logic rxf_rd_ready;

   // control and counter updates
   logic dma_enable;
   logic pkt_ingress;
   logic pkt_egress;
   logic [11:0] pkt_len;

   dma_bus_fsm i_bus_fsm (.*);

   dma_word_fifo #(
      .word_t (tx_word_t),
      .depth  (fifo_depth)
   ) i_tx_fifo (
      .cpci_clk (cpci_clk),
      .reset    (reset),
      .wr_valid (txf_wr_valid),
      .wr_data  (txf_wr_data),
      .wr_ready (txf_wr_ready),
      .rd_valid (txf_rd_valid),
      .rd_data  (txf_rd_data),
      .rd_ready (txf_rd_ready)
   );

   dma_word_fifo #(
      .word_t (rx_word_t),
      .depth  (fifo_depth)
   ) i_rx_fifo (
      .cpci_clk (cpci_clk),
      .reset    (reset),
      .wr_valid (rxf_wr_valid),
      .wr_data  (rxf_wr_data),
      .wr_ready (rxf_wr_ready),
      .rd_valid (rxf_rd_valid),
      .rd_data  (rxf_rd_data),
      .rd_ready (rxf_rd_ready)
   );

   dma_que_intfc i_que_intfc (.*);

   dma_regs i_regs (.*);

endmodule

//--- design/dma_word_fifo.sv
/* synchronous first-word-fall-through FIFO
   payload type is a parameter, head shows on rd_data while rd_valid is high */
module dma_word_fifo #(
   parameter type word_t = logic [7:0],
   parameter int depth = 16
) (
   input  logic cpci_clk,
   input  logic reset,
   input  logic wr_valid,
   input  word_t wr_data,
   output logic wr_ready,
   output logic rd_valid,
   output word_t rd_data,
   input  logic rd_ready
);

   localparam int ptr_width = $clog2(depth);

   word_t mem [depth];
   logic [ptr_width-1:0] wr_ptr;
   logic [ptr_width-1:0] rd_ptr;
   logic [ptr_width:0] count;
   logic push;
   logic pop;

   // flags come straight from the occupancy count
   assign wr_ready = (count != (ptr_width + 1)'(depth));
   assign rd_valid = (count != '0);
   assign push = wr_valid && wr_ready;
   assign pop = rd_valid && rd_ready;

   // head of queue
   assign rd_data = mem[rd_ptr];

   always_ff @(posedge cpci_clk) begin
      if (push)
         mem[wr_ptr] <= wr_data;
   end

   always_ff @(posedge cpci_clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
      end else begin
         // pointers wrap at depth, not only at a power of two
         if (push)
            wr_ptr <= (wr_ptr == ptr_width'(depth - 1)) ? '0 : wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= (rd_ptr == ptr_width'(depth - 1)) ? '0 : rd_ptr + 1'b1;
         // simultaneous push and pop leaves count alone
         if (push && !pop)
            count <= count + 1'b1;
         else if (pop && !push)
            count <= count - 1'b1;
      end
   end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# builds the DMA testbench with Verilator, runs it and decides pass or fail from the log

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
   echo "cannot enter the project root"
   exit 1
fi

log=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_dma -f sources.f -Mdir obj_dir -o tb_dma
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/tb_dma > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qx "Testbench passed" "$log"; then
   exit 0
fi
echo "pass message not found in $log"
exit 1

//--- sources.f
design/dma_defs_pkg.sv
design/dma_reg_pkg.sv
design/dma_word_fifo.sv
design/dma_bus_fsm.sv
design/dma_que_intfc.sv
design/dma_regs.sv
design/dma_top.sv
verif/tb_dma.sv

//--- verif/dma_patterns.txt
// header ttqq0lll: tt 01 transmit, 02 receive, ff end; qq queue; lll byte length
// packet data words follow each header; after the end marker: rx pkts, rx bytes, tx pkts, tx bytes
// alternating transmit and receive
01000001 a1000001
02000005 b0000001 b0000002
01010002 a2000001
02010008 b1000001 b1000002
01020003 a3000001
02020003 b2000001
01030004 a4000001
0203000c b3000001 b3000002 b3000003
// transmit lengths 5 to 9
01000005 a5000001 a5000002
01010006 a6000001 a6000002
01020007 a7000001 a7000002
01030008 a8000001 a8000002
01000009 a9000001 a9000002 a9000003
// end marker
ff000000
// expected counters
00000004 0000001c 00000009 0000002d

//--- verif/tb_dma.sv
/* testbench for the packet DMA engine, top module tb_dma
   replays verif/dma_patterns.txt against CPU queue models and checks host, queue and counters */
module tb_dma;
   import dma_defs_pkg::*;
   import dma_reg_pkg::*;

   localparam int clk_period = 40;
   localparam int drive_dly = 2;
   localparam int pat_size = 256;
   localparam int q_size = 64;

   logic cpci_clk;
   logic reset;
   logic dma_op_valid;
   logic dma_op_code;
   logic [3:0] dma_op_queue_id;
   logic dma_op_ready;
   logic dma_c2n_valid;
   logic [dma_data_width-1:0] dma_c2n_data;
   logic dma_c2n_ready;
   logic dma_n2c_valid;
   logic [dma_data_width-1:0] dma_n2c_data;
   logic dma_n2c_eop;
   valid_bytes_t dma_n2c_valid_bytes;
   logic dma_n2c_ready;
   logic [num_cpu_queues-1:0] cpu_q_dma_pkt_avail;
   logic [num_cpu_queues-1:0] cpu_q_dma_rd;
   logic [q_data_width-1:0] cpu_q_dma_rd_data;
   logic [q_ctrl_width-1:0] cpu_q_dma_rd_ctrl;
   logic [num_cpu_queues-1:0] cpu_q_dma_nearly_full;
   logic [num_cpu_queues-1:0] cpu_q_dma_wr;
   logic [q_data_width-1:0] cpu_q_dma_wr_data;
   logic [q_ctrl_width-1:0] cpu_q_dma_wr_ctrl;
   logic reg_req;
   logic reg_rd_wr_l;
   logic [dma_reg_addr_width-1:0] reg_addr;
   logic [reg_data_width-1:0] reg_wr_data;
   logic [reg_data_width-1:0] reg_rd_data;
   logic reg_ack;

   // pattern words and the index of the end marker
   logic [31:0] pat [pat_size];
   int pat_end;
   logic loaded;
   logic [31:0] rng;
   int errors;
   int checks;

   // receive queue models preloaded from the patterns
   logic [31:0] rxq_data [num_cpu_queues][q_size];
   logic [3:0] rxq_ctrl [num_cpu_queues][q_size];
   int rxq_wr [num_cpu_queues];
   int rxq_rd [num_cpu_queues];
   logic [num_cpu_queues-1:0] rd_seen;

   // expected transmit queue writes
   logic [31:0] exp_data [num_cpu_queues][q_size];
   logic [3:0] exp_ctrl [num_cpu_queues][q_size];
   int exp_wr [num_cpu_queues];
   int exp_rd [num_cpu_queues];

   dma_top i_dut (.*);

   initial begin
      cpci_clk = 1'b0;
      forever #(clk_period / 2) cpci_clk = ~cpci_clk;
   end

   ////////////////////////////////////////////////////////////
   // helpers
   ////////////////////////////////////////////////////////////

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic int word_count(input int len);
      return (len + 3) / 4;
   endfunction

   // last word ctrl has one bit at 4 minus the bytes it holds
   function automatic logic [3:0] last_ctrl(input int len);
      int nb;
      nb = (len % 4 == 0) ? 4 : len % 4;
      return 4'b0001 << (4 - nb);
   endfunction

   function automatic logic all_drained();
      logic done;
      done = 1'b1;
      for (int q = 0; q < num_cpu_queues; q++) begin
         if (exp_rd[q] != exp_wr[q] || rxq_rd[q] != rxq_wr[q])
            done = 1'b0;
      end
      return done;
   endfunction

   task automatic check(input logic [63:0] got, input logic [63:0] exp, input string msg);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error at %0t: %s, got %0h expected %0h", $time, msg, got, exp);
      end
   endtask

   task automatic load_rx_packet(input int base);
      int queue;
      int len;
      int n;
      queue = int'(pat[base][23:16]);
      len = int'(pat[base][10:0]);
      n = word_count(len);
      for (int i = 0; i < n; i++) begin
         rxq_data[queue][rxq_wr[queue]] = pat[base + 1 + i];
         rxq_ctrl[queue][rxq_wr[queue]] = (i == n - 1) ? last_ctrl(len) : 4'b0000;
         rxq_wr[queue]++;
      end
   endtask

   ////////////////////////////////////////////////////////////
   // host side drivers
   ////////////////////////////////////////////////////////////

   task automatic op_handshake(input logic code, input int queue);
      @(posedge cpci_clk);
      #drive_dly;
      dma_op_valid = 1'b1;
      dma_op_code = code;
      dma_op_queue_id = 4'(queue);
      @(negedge cpci_clk);
      while (!dma_op_ready)
         @(negedge cpci_clk);
      @(posedge cpci_clk);
      #drive_dly;
      dma_op_valid = 1'b0;
   endtask

   task automatic host_transmit(input int base);
      int queue;
      int len;
      int n;
      queue = int'(pat[base][23:16]);
      len = int'(pat[base][10:0]);
      n = word_count(len);
      for (int i = 0; i < n; i++) begin
         exp_data[queue][exp_wr[queue]] = pat[base + 1 + i];
         exp_ctrl[queue][exp_wr[queue]] = (i == n - 1) ? last_ctrl(len) : 4'b0000;
         exp_wr[queue]++;
      end
      op_handshake(dma_op_tx, queue);
      // the header is also the length word and its upper bits are ignored
      for (int i = 0; i <= n; i++) begin
         dma_c2n_valid = 1'b1;
         dma_c2n_data = pat[base + i];
         @(negedge cpci_clk);
         while (!dma_c2n_ready)
            @(negedge cpci_clk);
         @(posedge cpci_clk);
         #drive_dly;
      end
      dma_c2n_valid = 1'b0;
   endtask

   task automatic host_receive(input int base);
      int queue;
      int len;
      int n;
      int idx;
      logic held;
      logic [34:0] held_word;
      queue = int'(pat[base][23:16]);
      len = int'(pat[base][10:0]);
      n = word_count(len);
      idx = 0;
      held = 1'b0;
      held_word = '0;
      op_handshake(dma_op_rx, queue);
      while (idx < n) begin
         @(negedge cpci_clk);
         // stalled word stays put
         if (held) begin
            check(64'(dma_n2c_valid), 64'(1), "dma_n2c_valid dropped in stall");
            check(64'({dma_n2c_eop, dma_n2c_valid_bytes, dma_n2c_data}), 64'(held_word),
                  "receive word changed in stall");
         end
         held = dma_n2c_valid && !dma_n2c_ready;
         held_word = {dma_n2c_eop, dma_n2c_valid_bytes, dma_n2c_data};
         if (dma_n2c_valid && dma_n2c_ready) begin
            check(64'(dma_n2c_data), 64'(pat[base + 1 + idx]),
                  $sformatf("queue %0d receive data word %0d", queue, idx));
            check(64'(dma_n2c_eop), 64'(idx == n - 1), "receive eop");
            check(64'(dma_n2c_valid_bytes), (idx == n - 1) ? 64'(len % 4) : 64'(0),
                  "receive valid_bytes");
            idx++;
         end
      end
      @(posedge cpci_clk);
      #drive_dly;
   endtask

   // one request cycle with the ack expected on the next
   task automatic reg_access(input logic rd, input logic [2:0] addr, input logic [31:0] wdata,
                             output logic [31:0] rdata);
      @(posedge cpci_clk);
      #drive_dly;
      reg_req = 1'b1;
      reg_rd_wr_l = rd;
      reg_addr = addr;
      reg_wr_data = wdata;
      @(negedge cpci_clk);
      check(64'(reg_ack), 64'(0), "reg_ack in the request cycle");
      @(posedge cpci_clk);
      #drive_dly;
      reg_req = 1'b0;
      @(negedge cpci_clk);
      check(64'(reg_ack), 64'(1), "reg_ack one cycle after reg_req");
      rdata = reg_rd_data;
   endtask

   task automatic reg_read_check(input logic [2:0] addr, input logic [31:0] exp,
                                 input string msg);
      logic [31:0] rdata;
      reg_access(1'b1, addr, 32'h0, rdata);
      check(64'(rdata), 64'(exp), msg);
   endtask

   ////////////////////////////////////////////////////////////
   // queue models and random stalls
   ////////////////////////////////////////////////////////////

   always @(posedge cpci_clk) begin
      #drive_dly;
      rng = xorshift32(rng);
      // nearly full about one cycle in four per queue
      for (int q = 0; q < num_cpu_queues; q++)
         cpu_q_dma_nearly_full[q] = !reset && (rng[2*q +: 2] == 2'b00);
      dma_n2c_ready = !reset && (rng[9:8] != 2'b00);
      // read data one cycle after the strobe
      for (int q = 0; q < num_cpu_queues; q++) begin
         if (rd_seen[q] && rxq_rd[q] < rxq_wr[q]) begin
            cpu_q_dma_rd_data[q*dma_data_width +: dma_data_width] = rxq_data[q][rxq_rd[q]];
            cpu_q_dma_rd_ctrl[q*dma_ctrl_width +: dma_ctrl_width] = rxq_ctrl[q][rxq_rd[q]];
            rxq_rd[q]++;
         end else if (rd_seen[q]) begin
            errors++;
            $display("read strobe on empty receive queue %0d at %0t", q, $time);
         end
         cpu_q_dma_pkt_avail[q] = (rxq_rd[q] < rxq_wr[q]);
      end
   end

   // transmit writes arrive in order and never into a nearly full queue
   always @(negedge cpci_clk) begin
      rd_seen = reset ? '0 : cpu_q_dma_rd;
      for (int q = 0; q < num_cpu_queues; q++) begin
         if (!reset && cpu_q_dma_wr[q]) begin
            check(64'(cpu_q_dma_nearly_full[q]), 64'(0),
                  $sformatf("queue %0d written while nearly full", q));
            if (exp_rd[q] >= exp_wr[q]) begin
               errors++;
               $display("unexpected transmit write to queue %0d at %0t", q, $time);
            end else begin
               check(64'(cpu_q_dma_wr_data[q*dma_data_width +: dma_data_width]),
                     64'(exp_data[q][exp_rd[q]]), $sformatf("queue %0d transmit data", q));
               check(64'(cpu_q_dma_wr_ctrl[q*dma_ctrl_width +: dma_ctrl_width]),
                     64'(exp_ctrl[q][exp_rd[q]]), $sformatf("queue %0d transmit ctrl", q));
               exp_rd[q]++;
            end
         end
      end
   end

   // 200 cycles per pattern word
   initial begin
      int limit;
      wait (loaded);
      limit = ((pat_end < 0) ? pat_size : pat_end + 5) * 200;
      repeat (limit) @(posedge cpci_clk);
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("Testbench failed");
      $finish;
   end

   ////////////////////////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////////////////////////

   initial begin
      int base;
      logic [31:0] rdata;
      errors = 0;
      checks = 0;
      loaded = 1'b0;
      rng = 32'he4ed_d8e7;
      reset = 1'b1;
      dma_op_valid = 1'b0;
      dma_op_code = 1'b0;
      dma_op_queue_id = '0;
      dma_c2n_valid = 1'b0;
      dma_c2n_data = '0;
      dma_n2c_ready = 1'b0;
      cpu_q_dma_pkt_avail = '0;
      cpu_q_dma_rd_data = '0;
      cpu_q_dma_rd_ctrl = '0;
      cpu_q_dma_nearly_full = '0;
      reg_req = 1'b0;
      reg_rd_wr_l = 1'b1;
      reg_addr = '0;
      reg_wr_data = '0;
      rd_seen = '0;
      for (int q = 0; q < num_cpu_queues; q++) begin
         rxq_wr[q] = 0;
         rxq_rd[q] = 0;
         exp_wr[q] = 0;
         exp_rd[q] = 0;
      end

      // walk the records, preload receive packets, find the end marker
      $readmemh("verif/dma_patterns.txt", pat);
      base = 0;
      while (base < pat_size - 5 && pat[base][31:24] !== 8'hff) begin
         if (pat[base][31:24] == 8'h02)
            load_rx_packet(base);
         base += 1 + word_count(int'(pat[base][10:0]));
      end
      pat_end = (pat[base][31:24] === 8'hff) ? base : -1;
      loaded = 1'b1;

      @(posedge cpci_clk);
      @(negedge cpci_clk);
      check(64'({dma_op_ready, cpu_q_dma_rd, cpu_q_dma_wr, reg_ack, dma_n2c_valid,
                 dma_c2n_ready}), 64'(0), "outputs low in reset");
      @(posedge cpci_clk);
      #drive_dly;
      reset = 1'b0;

      if (pat_end < 0) begin
         errors++;
         $display("pattern file has no end marker");
      end else begin
         // disabled engine holds off a pending request
         reg_access(1'b0, reg_ctrl_addr, 32'h0, rdata);
         reg_read_check(reg_ctrl_addr, 32'h0, "ctrl after disable");
         @(posedge cpci_clk);
         #drive_dly;
         dma_op_valid = 1'b1;
         dma_op_code = (pat[0][31:24] == 8'h02) ? dma_op_rx : dma_op_tx;
         dma_op_queue_id = 4'(pat[0][19:16]);
         repeat (8) begin
            @(negedge cpci_clk);
            check(64'(dma_op_ready), 64'(0), "dma_op_ready while disabled");
         end
         @(posedge cpci_clk);
         #drive_dly;
         dma_op_valid = 1'b0;
         reg_access(1'b0, reg_ctrl_addr, 32'h1, rdata);
         reg_read_check(reg_ctrl_addr, 32'h1, "ctrl after enable");

         // operations back to back in file order
         base = 0;
         while (base < pat_end) begin
            if (pat[base][31:24] == 8'h02)
               host_receive(base);
            else
               host_transmit(base);
            base += 1 + word_count(int'(pat[base][10:0]));
         end
         while (!all_drained())
            @(negedge cpci_clk);
         // counter update trails the last word
         repeat (4) @(posedge cpci_clk);

         reg_read_check(reg_rx_pkts_addr, pat[pat_end + 1], "rx packet count");
         reg_read_check(reg_rx_bytes_addr, pat[pat_end + 2], "rx byte count");
         reg_read_check(reg_tx_pkts_addr, pat[pat_end + 3], "tx packet count");
         reg_read_check(reg_tx_bytes_addr, pat[pat_end + 4], "tx byte count");

         // enable plus clear and the clear bit reads back 0
         reg_access(1'b0, reg_ctrl_addr, 32'h3, rdata);
         reg_read_check(reg_rx_pkts_addr, 32'h0, "rx packets after clear");
         reg_read_check(reg_rx_bytes_addr, 32'h0, "rx bytes after clear");
         reg_read_check(reg_tx_pkts_addr, 32'h0, "tx packets after clear");
         reg_read_check(reg_tx_bytes_addr, 32'h0, "tx bytes after clear");
         reg_read_check(reg_ctrl_addr, 32'h1, "ctrl after clear");
         reg_read_check(3'd7, 32'h0, "unmapped address");
      end

      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule
